// File: logic/u1e_pkg.sv
/* u1e register side definitions */

package u1e_pkg;

   // bus widths
   typedef logic [10:0] wb_adr_t;   // byte address
   typedef logic [15:0] wb_dat_t;
   typedef logic [3:0]  unit_t;     // adr[10:7]
   typedef logic [6:0]  reg_ofs_t;  // adr[6:0]

   // settings bus
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // seconds in [63:32], ticks in [31:0]
   typedef logic [63:0] vita_time_t;

   ////////////////////////////////////////////////////////////////////////////
   // unit numbers
   localparam unit_t UNIT_MISC     = 4'd0;
   localparam unit_t UNIT_SETTINGS = 4'd5;

   ////////////////////////////////////////////////////////////////////////////
   // misc register bank offsets
   localparam reg_ofs_t REG_LEDS      = 7'd0;  // rw
   localparam reg_ofs_t REG_SWITCHES  = 7'd2;  // ro
   localparam reg_ofs_t REG_CGEN_CTRL = 7'd4;  // rw
   localparam reg_ofs_t REG_CGEN_ST   = 7'd6;  // ro
   localparam reg_ofs_t REG_TEST      = 7'd8;  // rw

   localparam wb_dat_t MISC_DEFAULT_RD = 16'hBEEF;
   localparam wb_dat_t CGEN_CTRL_RESET = 16'h0003;  // sync_b and ref_sel high

   ////////////////////////////////////////////////////////////////////////////
   // settings addresses of the time counter
   localparam set_addr_t SR_TIME64  = 8'd28;
   localparam set_addr_t TIME_SECS  = 8'd0;
   localparam set_addr_t TIME_TICKS = 8'd1;
   localparam set_addr_t TIME_CTRL  = 8'd2;

endpackage

// File: logic/wb_slave_if.sv
/* wishbone slave port */

`timescale 1ns/10ps

interface wb_slave_if;
   import u1e_pkg::*;

   wb_adr_t adr;
   wb_dat_t dat_mosi;   // master to slave
   wb_dat_t dat_miso;   // slave to master
   logic    we;
   logic    cyc;
   logic    stb;
   logic    ack;

   modport master
   (
      output adr, dat_mosi, we, cyc, stb,
      input  dat_miso, ack
   );

   modport slave
   (
      input  adr, dat_mosi, we, cyc, stb,
      output dat_miso, ack
   );

endinterface

// File: logic/wb_decoder.sv
/* single master wishbone decoder */

`timescale 1ns/10ps

module wb_decoder
(
   input  u1e_pkg::wb_adr_t adr_i,
   input  u1e_pkg::wb_dat_t dat_i,
   input  logic             we_i,
   input  logic             stb_i,
   input  logic             cyc_i,
   output u1e_pkg::wb_dat_t dat_o,
   output logic             ack_o,
   wb_slave_if.master       misc_bus,
   wb_slave_if.master       set_bus
);
   import u1e_pkg::*;

   unit_t unit;

   assign unit = adr_i[10:7];

   // shared lines go to every unit
   assign misc_bus.adr      = adr_i;
   assign misc_bus.dat_mosi = dat_i;
   assign misc_bus.we       = we_i;
   assign misc_bus.cyc      = cyc_i;
   assign misc_bus.stb      = stb_i & (unit == UNIT_MISC);

   assign set_bus.adr       = adr_i;
   assign set_bus.dat_mosi  = dat_i;
   assign set_bus.we        = we_i;
   assign set_bus.cyc       = cyc_i;
   assign set_bus.stb       = stb_i & (unit == UNIT_SETTINGS);

   // return path
   always_comb
   begin
      case (unit)
         UNIT_MISC:
         begin
            dat_o = misc_bus.dat_miso;
            ack_o = misc_bus.ack;
         end
         UNIT_SETTINGS:
         begin
            dat_o = set_bus.dat_miso;
            ack_o = set_bus.ack;
         end
         default:
         begin
            dat_o = '0;                // nothing mapped here
            ack_o = cyc_i & stb_i;     // answer anyway so the master never hangs
         end
      endcase
   end

endmodule

// File: logic/misc_regs.sv
/* misc register bank */

`timescale 1ns/10ps

module misc_regs
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   wb_slave_if.slave  bus,
   input  logic [2:0] debug_pb_i,
   input  logic [7:0] dip_sw_i,
   input  logic [2:0] cgen_st_i,
   output logic [2:0] debug_led_o,
   output logic       cgen_sync_b_o,
   output logic       cgen_ref_sel_o
);
   import u1e_pkg::*;

   wb_dat_t  reg_leds;
   wb_dat_t  reg_cgen_ctrl;
   wb_dat_t  reg_test;
   reg_ofs_t ofs;
   logic     wr_en;

   assign ofs   = bus.adr[6:0];
   assign wr_en = bus.cyc & bus.stb & bus.we;

   ////////////////////////////////////////////////////////////////////////////
   // writable registers

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= CGEN_CTRL_RESET;
         reg_test      <= '0;
      end
      else if (wr_en)
      begin
         case (ofs)
            REG_LEDS:      reg_leds      <= bus.dat_mosi;
            REG_CGEN_CTRL: reg_cgen_ctrl <= bus.dat_mosi;
            REG_TEST:      reg_test      <= bus.dat_mosi;
            default:       ;  // read-only or unmapped
         endcase
      end
   end

   // leds are wired out of order on the board
   assign debug_led_o[2] = reg_leds[0];
   assign debug_led_o[0] = reg_leds[1];
   assign debug_led_o[1] = reg_leds[2];

   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];

   ////////////////////////////////////////////////////////////////////////////
   // read mux

   always_comb
   begin
      case (ofs)
         REG_LEDS:      bus.dat_miso = reg_leds;
         REG_SWITCHES:  bus.dat_miso = {5'd0, debug_pb_i, dip_sw_i};
         REG_CGEN_CTRL: bus.dat_miso = reg_cgen_ctrl;
         REG_CGEN_ST:   bus.dat_miso = {13'd0, cgen_st_i};
         REG_TEST:      bus.dat_miso = reg_test;
         default:       bus.dat_miso = MISC_DEFAULT_RD;
      endcase
   end

   assign bus.ack = bus.cyc & bus.stb;

endmodule

// File: logic/settings_bus.sv
/* 16 to 32 bit settings bus */

`timescale 1ns/10ps

module settings_bus
(
   input  logic                wb_clk,
   input  logic                wb_rst,
   wb_slave_if.slave           bus,
   output logic                set_stb_o,
   output u1e_pkg::set_addr_t  set_addr_o,
   output u1e_pkg::set_data_t  set_data_o
);
   import u1e_pkg::*;

   wb_dat_t low_half;
   logic    wr_en;

   assign wr_en = bus.cyc & bus.stb & bus.we;

   // low half and assembled word
   always_ff @(posedge wb_clk)
   begin
      if (wr_en & ~bus.adr[1])
         low_half <= bus.dat_mosi;
      if (wr_en & bus.adr[1])
      begin
         set_data_o <= {bus.dat_mosi, low_half};
         set_addr_o <= {3'd0, bus.adr[6:2]};  // 32 registers
      end
   end

   // high half write fires the strobe
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr_en & bus.adr[1];
   end

   assign bus.dat_miso = '0;  // write only
   assign bus.ack      = bus.cyc & bus.stb;

endmodule

// File: logic/vita_timer.sv
/* vita time counter */

`timescale 1ns/10ps

module vita_timer
#(
   parameter logic [31:0] TICKS_PER_SEC = 32'd64000000
)
(
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  logic                 set_stb_i,
   input  u1e_pkg::set_addr_t   set_addr_i,
   input  u1e_pkg::set_data_t   set_data_i,
   input  logic                 pps_i,
   output u1e_pkg::vita_time_t  vita_time_o,
   output logic                 pps_int_o
);
   import u1e_pkg::*;

   localparam set_addr_t ADDR_SECS  = SR_TIME64 + TIME_SECS;
   localparam set_addr_t ADDR_TICKS = SR_TIME64 + TIME_TICKS;
   localparam set_addr_t ADDR_CTRL  = SR_TIME64 + TIME_CTRL;

   set_data_t  secs_stage;
   set_data_t  ticks_stage;
   vita_time_t time_q;
   logic [2:0] pps_sync;  // two sync stages plus edge delay
   logic       pps_det;
   logic       armed;     // waiting for pps
   logic       ctrl_wr;
   logic       load_now;
   logic       last_tick;

   assign pps_det   = pps_sync[1] & ~pps_sync[2];
   assign ctrl_wr   = set_stb_i & (set_addr_i == ADDR_CTRL);
   assign load_now  = (ctrl_wr & set_data_i[0]) | (armed & pps_det);
   assign last_tick = (time_q[31:0] == TICKS_PER_SEC - 32'd1);

   ////////////////////////////////////////////////////////////////////////////
   // staged time, applied on the next load
   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && (set_addr_i == ADDR_SECS))
         secs_stage <= set_data_i;
      if (set_stb_i && (set_addr_i == ADDR_TICKS))
         ticks_stage <= set_data_i;
   end

   ////////////////////////////////////////////////////////////////////////////
   // counter and pps
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_sync  <= '0;
         pps_int_o <= 1'b0;
         armed     <= 1'b0;
         time_q    <= '0;
      end
      else
      begin
         pps_sync  <= {pps_sync[1:0], pps_i};
         pps_int_o <= pps_det;

         if (ctrl_wr)
            armed <= ~set_data_i[0];  // bit 0 clear waits for pps
         else if (armed & pps_det)
            armed <= 1'b0;

         if (load_now)
            time_q <= {secs_stage, ticks_stage};
         else if (last_tick)
            time_q <= {time_q[63:32] + 32'd1, 32'd0};  // next second
         else
            time_q[31:0] <= time_q[31:0] + 32'd1;
      end
   end

   assign vita_time_o = time_q;

endmodule

// File: logic/u1e_core.sv
/* u1e register core */

`timescale 1ns/10ps

module u1e_core
#(
   parameter logic [31:0] TICKS_PER_SEC = 32'd64000000
)
(
   input  logic                 wb_clk,
   input  logic                 wb_rst,

   // wishbone master side
   input  u1e_pkg::wb_adr_t     wb_adr_i,
   input  u1e_pkg::wb_dat_t     wb_dat_i,
   input  logic                 wb_we_i,
   input  logic                 wb_stb_i,
   input  logic                 wb_cyc_i,
   output u1e_pkg::wb_dat_t     wb_dat_o,
   output logic                 wb_ack_o,

   // board
   input  logic [2:0]           debug_pb_i,
   input  logic [7:0]           dip_sw_i,
   input  logic [2:0]           cgen_st_i,
   input  logic                 pps_i,
   output logic [2:0]           debug_led_o,
   output logic                 cgen_sync_b_o,
   output logic                 cgen_ref_sel_o,
   output u1e_pkg::vita_time_t  vita_time_o,
   output logic                 pps_int_o
);
   import u1e_pkg::*;

   logic      set_stb;
   set_addr_t set_addr;
   set_data_t set_data;

   wb_slave_if misc_bus ();  // unit 0
   wb_slave_if set_bus ();   // unit 5

   ////////////////////////////////////////////////////////////////////////////
   // bus decode

   wb_decoder i_decoder
   (
      .adr_i    (wb_adr_i),
      .dat_i    (wb_dat_i),
      .we_i     (wb_we_i),
      .stb_i    (wb_stb_i),
      .cyc_i    (wb_cyc_i),
      .dat_o    (wb_dat_o),
      .ack_o    (wb_ack_o),
      .misc_bus (misc_bus.master),
      .set_bus  (set_bus.master)
   );

   ////////////////////////////////////////////////////////////////////////////
   // units

   misc_regs i_misc
   (
      .wb_clk         (wb_clk),
      .wb_rst         (wb_rst),
      .bus            (misc_bus.slave),
      .debug_pb_i     (debug_pb_i),
      .dip_sw_i       (dip_sw_i),
      .cgen_st_i      (cgen_st_i),
      .debug_led_o    (debug_led_o),
      .cgen_sync_b_o  (cgen_sync_b_o),
      .cgen_ref_sel_o (cgen_ref_sel_o)
   );

   settings_bus i_settings
   (
      .wb_clk     (wb_clk),
      .wb_rst     (wb_rst),
      .bus        (set_bus.slave),
      .set_stb_o  (set_stb),
      .set_addr_o (set_addr),
      .set_data_o (set_data)
   );

   vita_timer #(.TICKS_PER_SEC(TICKS_PER_SEC)) i_timer
   (
      .wb_clk      (wb_clk),
      .wb_rst      (wb_rst),
      .set_stb_i   (set_stb),
      .set_addr_i  (set_addr),
      .set_data_i  (set_data),
      .pps_i       (pps_i),
      .vita_time_o (vita_time_o),
      .pps_int_o   (pps_int_o)
   );

endmodule

// File: dv/u1e_core_chk.sv
/* bus and settings timing checks */

`timescale 1ns/10ps

module u1e_core_chk
#(
   parameter logic [31:0] TICKS_PER_SEC = 32'd64000000
)
(
   input logic                 wb_clk,
   input logic                 wb_rst,
   input logic                 wb_cyc_i,
   input logic                 wb_stb_i,
   input logic                 wb_ack_i,
   input logic                 set_stb_i,
   input u1e_pkg::vita_time_t  vita_time_i
);

   // ack only inside an active cycle
   ack_in_cycle: assert property (@(posedge wb_clk) disable iff (wb_rst)
      wb_ack_i |-> (wb_cyc_i && wb_stb_i))
      else $error("wb_ack_o high without cyc and stb");

   stb_single: assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_stb_i |=> !set_stb_i)
      else $error("settings strobe high two cycles in a row");

   ticks_range: assert property (@(posedge wb_clk) disable iff (wb_rst)
      vita_time_i[31:0] < TICKS_PER_SEC)
      else $error("ticks field at or above TICKS_PER_SEC");  // wrap missed

endmodule

// File: dv/u1e_core_tb.sv
/* u1e core testbench */

`timescale 1ns/10ps

module u1e_core_tb;
   import u1e_pkg::*;

   typedef enum logic [2:0] {OP_WR, OP_RD, OP_PPS, OP_TIME, OP_PINS, OP_IDLE} op_t;

   typedef struct packed
   {
      op_t         op;
      logic [2:0]  test;
      wb_adr_t     adr;
      wb_dat_t     dat;   // write data, expected read or pin word
      logic [31:0] secs;  // expected seconds
      logic [31:0] lo;    // ticks window, or idle cycles
      logic [31:0] hi;
   } step_t;

   logic        wb_clk = 1'b0;
   logic        wb_rst;
   wb_adr_t     wb_adr_i;
   wb_dat_t     wb_dat_i;
   logic        wb_we_i;
   logic        wb_stb_i;
   logic        wb_cyc_i;
   wb_dat_t     wb_dat_o;
   logic        wb_ack_o;
   logic [2:0]  debug_pb_i;
   logic [7:0]  dip_sw_i;
   logic [2:0]  cgen_st_i;
   logic        pps_i;
   logic [2:0]  debug_led_o;
   logic        cgen_sync_b_o;
   logic        cgen_ref_sel_o;
   vita_time_t  vita_time_o;
   logic        pps_int_o;

   step_t       steps[$];
   logic [2:0]  cur_test;
   logic [31:0] lfsr_state;
   int          pass_cnt = 0;
   int          fail_cnt = 0;
   int          test_fails = 0;
   logic        table_built = 1'b0;

   always #2 wb_clk = ~wb_clk;  // 4 ns period

   u1e_core #(.TICKS_PER_SEC(32'd100)) i_dut
   (
      .wb_clk         (wb_clk),
      .wb_rst         (wb_rst),
      .wb_adr_i       (wb_adr_i),
      .wb_dat_i       (wb_dat_i),
      .wb_we_i        (wb_we_i),
      .wb_stb_i       (wb_stb_i),
      .wb_cyc_i       (wb_cyc_i),
      .wb_dat_o       (wb_dat_o),
      .wb_ack_o       (wb_ack_o),
      .debug_pb_i     (debug_pb_i),
      .dip_sw_i       (dip_sw_i),
      .cgen_st_i      (cgen_st_i),
      .pps_i          (pps_i),
      .debug_led_o    (debug_led_o),
      .cgen_sync_b_o  (cgen_sync_b_o),
      .cgen_ref_sel_o (cgen_ref_sel_o),
      .vita_time_o    (vita_time_o),
      .pps_int_o      (pps_int_o)
   );

   bind u1e_core u1e_core_chk #(.TICKS_PER_SEC(TICKS_PER_SEC)) i_chk
   (
      .wb_clk      (wb_clk),
      .wb_rst      (wb_rst),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .wb_ack_i    (wb_ack_o),
      .set_stb_i   (set_stb),
      .vita_time_i (vita_time_o)
   );

   ////////////////////////////////////////////////////////////////////////////
   // random source, taps 32 22 2 1

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] draw_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // register bits 0,1,2 land on led 2,0,1
   function automatic logic [2:0] board_leds(input wb_dat_t d);
      return {d[0], d[2], d[1]};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // stimulus table

   function automatic void add_step(input op_t op, input wb_adr_t adr, input wb_dat_t dat,
                                    input logic [31:0] secs = 32'd0,
                                    input logic [31:0] lo = 32'd0,
                                    input logic [31:0] hi = 32'd0);
      steps.push_back('{op, cur_test, adr, dat, secs, lo, hi});
   endfunction

   // low half first, high half fires the strobe
   function automatic void add_settings_write(input set_addr_t r, input set_data_t v);
      add_step(OP_WR, {UNIT_SETTINGS, r[4:0], 2'b00}, v[15:0]);
      add_step(OP_WR, {UNIT_SETTINGS, r[4:0], 2'b10}, v[31:16]);
   endfunction

   task automatic build_table();
      wb_dat_t test_val;
      dip_sw_i   = 8'(draw_bits(8));
      debug_pb_i = 3'(draw_bits(3));
      cgen_st_i  = 3'(draw_bits(3));
      test_val   = 16'(draw_bits(16));

      cur_test = 3'd1;
      add_step(OP_RD, {UNIT_MISC, REG_LEDS}, 16'h0000);
      add_step(OP_RD, {UNIT_MISC, REG_TEST}, 16'h0000);
      add_step(OP_RD, {UNIT_MISC, REG_CGEN_CTRL}, 16'h0003);
      add_step(OP_PINS, '0, {11'd0, 3'b000, 2'b11});

      cur_test = 3'd2;
      add_step(OP_WR, {UNIT_MISC, REG_LEDS}, 16'h0005);
      add_step(OP_WR, {UNIT_MISC, REG_CGEN_CTRL}, 16'h0002);
      add_step(OP_WR, {UNIT_MISC, REG_TEST}, test_val);
      add_step(OP_RD, {UNIT_MISC, REG_LEDS}, 16'h0005);
      add_step(OP_RD, {UNIT_MISC, REG_CGEN_CTRL}, 16'h0002);
      add_step(OP_RD, {UNIT_MISC, REG_TEST}, test_val);
      add_step(OP_PINS, '0, {11'd0, board_leds(16'h0005), 2'b10});  // sync_b, ref_sel
      add_step(OP_WR, {UNIT_MISC, REG_LEDS}, 16'h0006);
      add_step(OP_PINS, '0, {11'd0, board_leds(16'h0006), 2'b10});

      cur_test = 3'd3;
      add_step(OP_RD, {UNIT_MISC, REG_SWITCHES}, {5'd0, debug_pb_i, dip_sw_i});
      add_step(OP_RD, {UNIT_MISC, REG_CGEN_ST}, {13'd0, cgen_st_i});
      add_step(OP_RD, {UNIT_MISC, 7'd12}, 16'hBEEF);
      add_step(OP_RD, {4'd3, 7'd0}, 16'h0000);  // unmapped unit

      cur_test = 3'd4;
      add_settings_write(SR_TIME64 + TIME_SECS, 32'd5);
      add_settings_write(SR_TIME64 + TIME_TICKS, 32'd10);
      add_settings_write(SR_TIME64 + TIME_CTRL, 32'd1);
      add_step(OP_TIME, '0, 16'd0, 32'd5, 32'd10, 32'd12);

      cur_test = 3'd5;
      add_step(OP_IDLE, '0, 16'd0, 32'd0, 32'd95);
      add_step(OP_TIME, '0, 16'd0, 32'd6, 32'd0, 32'd30);  // one second later
      add_settings_write(SR_TIME64 + TIME_SECS, 32'd9);
      add_settings_write(SR_TIME64 + TIME_CTRL, 32'd0);     // wait for pps
      add_step(OP_TIME, '0, 16'd0, 32'd6, 32'd0, 32'd30);  // still counting
      add_step(OP_PPS, '0, 16'd0, 32'd9);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // checks

   function automatic void count_fail();
      fail_cnt++;
      test_fails++;
   endfunction

   task automatic check_value(input string sig, input logic [63:0] exp,
                              input logic [63:0] act);
      assert (act === exp)
         pass_cnt++;
      else
      begin
         count_fail();
         $display("FAILED %0t %s: expected %0h, got %0h", $time, sig, exp, act);
      end
   endtask

   task automatic check_window(input string sig, input logic [31:0] lo,
                               input logic [31:0] hi, input logic [31:0] act);
      assert ((act >= lo) && (act <= hi))
         pass_cnt++;
      else
      begin
         count_fail();
         $display("FAILED %0t %s: expected %0d..%0d, got %0d", $time, sig, lo, hi, act);
      end
   endtask

   // entered 1 ns after a rising edge, leaves 1 ns after the ack edge
   task automatic bus_cycle(input wb_adr_t adr, input wb_dat_t dat, input logic we,
                            output wb_dat_t rdat);
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_we_i  = we;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      #2;
      while (!wb_ack_o)
      begin
         @(posedge wb_clk);
         #3;
      end
      rdat = wb_dat_o;
      @(posedge wb_clk);
      #1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic next_cycle();
      @(posedge wb_clk);
      #1;
   endtask

   task automatic run_step(input step_t s);
      wb_dat_t rdat;
      int      n;
      case (s.op)
         OP_WR:
            bus_cycle(s.adr, s.dat, 1'b1, rdat);
         OP_RD:
         begin
            bus_cycle(s.adr, 16'd0, 1'b0, rdat);
            check_value("wb_dat_o", 64'(s.dat), 64'(rdat));
         end
         OP_PINS:
         begin
            check_value("debug_led_o", 64'(s.dat[4:2]), 64'(debug_led_o));
            check_value("cgen_sync_b_o", 64'(s.dat[1]), 64'(cgen_sync_b_o));
            check_value("cgen_ref_sel_o", 64'(s.dat[0]), 64'(cgen_ref_sel_o));
         end
         OP_IDLE:
            repeat (s.lo) next_cycle();
         OP_TIME:
         begin
            repeat (2) next_cycle();  // strobe, then load
            check_value("vita_time_o seconds", 64'(s.secs), 64'(vita_time_o[63:32]));
            check_window("vita_time_o ticks", s.lo, s.hi, vita_time_o[31:0]);
         end
         default:  // pps edge
         begin
            pps_i = 1'b1;
            n = 0;
            while (!pps_int_o && (n < 5))
            begin
               next_cycle();
               n++;
            end
            assert (pps_int_o)
               pass_cnt++;
            else
            begin
               count_fail();
               $display("pps_int_o did not pulse within 5 cycles of the pps rise");
            end
            check_value("vita_time_o seconds", 64'(s.secs), 64'(vita_time_o[63:32]));
            pps_i = 1'b0;
         end
      endcase
   endtask

   function automatic string test_title(input logic [2:0] t);
      case (t)
         3'd1:    return "reset values";
         3'd2:    return "read/write registers";
         3'd3:    return "read-only words";
         3'd4:    return "immediate time load";
         default: return "rollover and pps load";
      endcase
   endfunction

   task automatic report_test(input logic [2:0] t);
      if (test_fails == 0)
         $display("test %0d, %s: ok", t, test_title(t));
      else
         $display("test %0d, %s: %0d errors", t, test_title(t), test_fails);
      test_fails = 0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence

   initial
   begin
      wb_rst     = 1'b1;
      wb_adr_i   = '0;
      wb_dat_i   = '0;
      wb_we_i    = 1'b0;
      wb_stb_i   = 1'b0;
      wb_cyc_i   = 1'b0;
      pps_i      = 1'b0;
      lfsr_state = 32'hbf48_3abc;
      build_table();
      table_built = 1'b1;

      repeat (16) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;

      for (int i = 0; i < steps.size(); i++)
      begin
         run_step(steps[i]);
         if ((i == steps.size() - 1) || (steps[i + 1].test != steps[i].test))
            report_test(steps[i].test);
      end

      $display("totals: %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   // budget of 20 cycles per table entry on top of reset
   initial
   begin
      wait (table_built);
      repeat (16 + steps.size() * 20) @(posedge wb_clk);
      $display("timeout: the stimulus table did not finish in the expected time");
      $display("Checks failed");
      $finish;
   end

endmodule

// File: list.f
logic/u1e_pkg.sv
logic/wb_slave_if.sv
logic/wb_decoder.sv
logic/misc_regs.sv
logic/settings_bus.sv
logic/vita_timer.sv
logic/u1e_core.sv
dv/u1e_core_chk.sv
dv/u1e_core_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the u1e core testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module u1e_core_tb \
      -f list.f -o u1e_core_sim; then
   echo "verilator build failed"
   exit 1
fi

if ! ./obj_dir/u1e_core_sim > "$LOG" 2>&1; then
   cat "$LOG"
   echo "simulation ended with an error status"
   exit 1
fi

cat "$LOG"

if grep -q "All checks passed" "$LOG"; then
   exit 0
fi
exit 1
